// ==== hw/rvIsaPkg.sv ====
/* RV32I subset encodings: word and register index types,
   major opcodes, funct3 and funct7 values, ALU operations */
package rvIsaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;

    // major opcodes, anything else halts the core
    typedef enum logic [6:0] {
        OpCompute = 7'b0110011,
        OpImm     = 7'b0010011,
        OpLui     = 7'b0110111,
        OpLoad    = 7'b0000011,
        OpStore   = 7'b0100011,
        OpBranch  = 7'b1100011,
        OpSystem  = 7'b1110011
    } opcodeE;

    typedef enum logic [3:0] {
        AluAdd = 4'd0,
        AluSub = 4'd1,
        AluAnd = 4'd2,
        AluOr  = 4'd3,
        AluXor = 4'd4,
        AluSlt = 4'd5,
        AluSll = 4'd6,
        AluSrl = 4'd7
    } aluOpE;

    // funct3 of compute and immediate compute
    localparam logic [2:0] Funct3AddSub = 3'b000;
    localparam logic [2:0] Funct3Sll    = 3'b001;
    localparam logic [2:0] Funct3Slt    = 3'b010;
    localparam logic [2:0] Funct3Xor    = 3'b100;
    localparam logic [2:0] Funct3Srl    = 3'b101;
    localparam logic [2:0] Funct3Or     = 3'b110;
    localparam logic [2:0] Funct3And    = 3'b111;

    // word-sized lw and sw
    localparam logic [2:0] Funct3Word   = 3'b010;

    // branch conditions
    localparam logic [2:0] Funct3Beq    = 3'b000;
    localparam logic [2:0] Funct3Bne    = 3'b001;

    // funct7 of the base ops and of sub
    localparam logic [6:0] Funct7Base   = 7'b0000000;
    localparam logic [6:0] Funct7Sub    = 7'b0100000;

endpackage

// ==== hw/pipePkg.sv ====
/* control bundle, pipeline register layouts and the data-memory request */
package pipePkg;
    import rvIsaPkg::*;

    // decoded control, travels with the instruction into EX
    typedef struct packed {
        aluOpE aluOp;
        logic  srcBImm;
        logic  regWrEn;
        logic  memRd;
        logic  memWr;
        logic  isBranch;
        logic  branchNe;
        logic  isHalt;
    } ctrlT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT inst;
    } ifIdT;

    typedef struct packed {
        logic   valid;
        ctrlT   ctrl;
        wordT   pc;
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
        wordT   rs1Data;
        wordT   rs2Data;
        wordT   imm;
    } idExT;

    typedef struct packed {
        logic   valid;
        logic   regWrEn;
        logic   memRd;
        logic   memWr;
        logic   isHalt;
        regIdxT rd;
        wordT   aluResult;
        wordT   storeData;
    } exMemT;

    // also the register-file write port and the late forwarding source
    typedef struct packed {
        logic   valid;
        logic   regWrEn;
        logic   isHalt;
        regIdxT rd;
        wordT   wbData;
    } memWbT;

    typedef struct packed {
        wordT addr;
        logic wrEn;
        wordT wrData;
    } dataReqT;

endpackage

// ==== hw/fetchStage.sv ====
/* instruction fetch: program counter with hold and redirect, IF/ID register */
module fetchStage
    import rvIsaPkg::*, pipePkg::*;
#(
    parameter wordT ResetPc = '0
) (
    input  logic CLK,
    input  logic arstN,
    input  logic hold,
    input  logic redirect,
    input  wordT redirectPc,
    input  wordT instWord,
    output wordT instAddr,
    output ifIdT ifId
);

    wordT pc;

    // instruction memory answers in the same cycle
    assign instAddr = pc;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc   <= ResetPc;
            ifId <= '0;
        end else if (redirect) begin
            // squash the wrong-path fetch
            pc         <= redirectPc;
            ifId.valid <= 1'b0;
        end else if (!hold) begin
            pc   <= pc + 32'd4;
            ifId <= '{valid: 1'b1, pc: pc, inst: instWord};
        end
    end

    // branch targets from EX land on whole words
    assert property (@(posedge CLK) disable iff (!arstN)
        redirect |-> redirectPc[1:0] == 2'b00)
        else $error("misaligned redirect target %h", redirectPc);

endmodule

// ==== hw/decodeStage.sv ====
/* instruction decode: control and immediates, register file, load-use
   stall, sticky halt and the ID/EX register */
module decodeStage
    import rvIsaPkg::*, pipePkg::*;
(
    input  logic  CLK,
    input  logic  arstN,
    input  ifIdT  ifId,
    input  logic  redirect,
    input  memWbT memWb,
    output logic  hold,
    output idExT  idEx
);

    wordT       regFile [32];
    opcodeE     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regIdxT     rs1Idx;
    regIdxT     rs2Idx;
    regIdxT     rdIdx;
    ctrlT       ctrl;
    wordT       imm;
    wordT       rs1Data;
    wordT       rs2Data;
    logic       usesRs1;
    logic       usesRs2;
    logic       badFunct;
    logic       rfWrEn;
    logic       loadUse;
    logic       haltSeen;

    assign opcode = opcodeE'(ifId.inst[6:0]);
    assign funct3 = ifId.inst[14:12];
    assign funct7 = ifId.inst[31:25];
    assign rdIdx  = ifId.inst[11:7];
    assign rs2Idx = ifId.inst[24:20];
    // lui reads x0, so the ALU adds zero to the upper immediate
    assign rs1Idx = (opcode == OpLui) ? '0 : ifId.inst[19:15];

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = AluAdd;
        usesRs1    = 1'b0;
        usesRs2    = 1'b0;
        badFunct   = 1'b0;
        case (opcode)
            OpCompute, OpImm: begin
                usesRs1      = 1'b1;
                usesRs2      = (opcode == OpCompute);
                ctrl.srcBImm = (opcode == OpImm);
                ctrl.regWrEn = 1'b1;
                case (funct3)
                    Funct3AddSub: begin
                        ctrl.aluOp = (opcode == OpCompute && funct7 == Funct7Sub) ?
                                     AluSub : AluAdd;
                    end
                    Funct3Sll: ctrl.aluOp = AluSll;
                    Funct3Slt: ctrl.aluOp = AluSlt;
                    Funct3Xor: ctrl.aluOp = AluXor;
                    Funct3Srl: ctrl.aluOp = AluSrl;
                    Funct3Or:  ctrl.aluOp = AluOr;
                    Funct3And: ctrl.aluOp = AluAnd;
                    default:   badFunct = 1'b1;
                endcase
                // funct7 only matters for register ops and shifts
                if (opcode == OpCompute || funct3 inside {Funct3Sll, Funct3Srl}) begin
                    badFunct = badFunct | !(funct7 == Funct7Base ||
                        (opcode == OpCompute && funct3 == Funct3AddSub &&
                         funct7 == Funct7Sub));
                end
            end
            OpLui: begin
                ctrl.srcBImm = 1'b1;
                ctrl.regWrEn = 1'b1;
            end
            OpLoad: begin
                usesRs1      = 1'b1;
                ctrl.srcBImm = 1'b1;
                ctrl.regWrEn = 1'b1;
                ctrl.memRd   = 1'b1;
                badFunct     = (funct3 != Funct3Word);
            end
            OpStore: begin
                usesRs1      = 1'b1;
                usesRs2      = 1'b1;
                ctrl.srcBImm = 1'b1;
                ctrl.memWr   = 1'b1;
                badFunct     = (funct3 != Funct3Word);
            end
            OpBranch: begin
                usesRs1       = 1'b1;
                usesRs2       = 1'b1;
                ctrl.isBranch = 1'b1;
                ctrl.branchNe = (funct3 == Funct3Bne);
                badFunct      = !(funct3 inside {Funct3Beq, Funct3Bne});
            end
            // ecall, every other system op and unknown opcodes
            default: ctrl.isHalt = 1'b1;
        endcase
        if (badFunct) begin
            ctrl        = '0;
            ctrl.isHalt = 1'b1;
            usesRs1     = 1'b0;
            usesRs2     = 1'b0;
        end
        // x0 is never a write target
        if (rdIdx == '0) begin
            ctrl.regWrEn = 1'b0;
        end
    end

    always_comb begin
        case (opcode)
            OpStore:  imm = {{20{ifId.inst[31]}}, ifId.inst[31:25], ifId.inst[11:7]};
            OpBranch: imm = {{20{ifId.inst[31]}}, ifId.inst[7], ifId.inst[30:25],
                             ifId.inst[11:8], 1'b0};
            OpLui:    imm = {ifId.inst[31:12], 12'b0};
            default:  imm = {{20{ifId.inst[31]}}, ifId.inst[31:20]};
        endcase
    end

    assign rfWrEn = memWb.valid && memWb.regWrEn;

    always_ff @(posedge CLK) begin
        if (rfWrEn) begin
            regFile[memWb.rd] <= memWb.wbData;
        end
    end

    // writeback in the same cycle passes straight through
    function automatic wordT readReg(regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        if (rfWrEn && memWb.rd == idx) begin
            return memWb.wbData;
        end
        return regFile[idx];
    endfunction

    always_comb begin
        rs1Data = readReg(rs1Idx);
        rs2Data = readReg(rs2Idx);
    end

    // load in EX whose result is needed here
    assign loadUse = ifId.valid && idEx.valid && idEx.ctrl.memRd && idEx.ctrl.regWrEn &&
                     ((usesRs1 && rs1Idx == idEx.rd) || (usesRs2 && rs2Idx == idEx.rd));
    assign hold = loadUse || haltSeen;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            haltSeen <= 1'b0;
            idEx     <= '0;
        end else if (redirect || hold) begin
            idEx.valid <= 1'b0;
        end else begin
            haltSeen <= ifId.valid && ctrl.isHalt;
            idEx     <= '{valid: ifId.valid, ctrl: ctrl, pc: ifId.pc,
                          rs1: rs1Idx, rs2: rs2Idx, rd: rdIdx,
                          rs1Data: rs1Data, rs2Data: rs2Data, imm: imm};
        end
    end

    // writes to x0 are dropped at decode, never by the register file
    assert property (@(posedge CLK) disable iff (!arstN)
        rfWrEn |-> memWb.rd != '0)
        else $error("register x0 written");

endmodule

// ==== hw/executeStage.sv ====
/* execute: operand forwarding, ALU, branch resolution, EX/MEM register */
module executeStage
    import rvIsaPkg::*, pipePkg::*;
(
    input  logic  CLK,
    input  logic  arstN,
    input  idExT  idEx,
    input  memWbT memWb,
    output logic  redirect,
    output wordT  redirectPc,
    output exMemT exMem
);

    wordT opA;
    wordT opB;
    wordT rs2Fwd;
    wordT aluResult;
    logic taken;

    // youngest producer wins
    function automatic wordT forward(regIdxT idx, wordT regData);
        if (exMem.valid && exMem.regWrEn && exMem.rd == idx) begin
            return exMem.aluResult;
        end
        if (memWb.valid && memWb.regWrEn && memWb.rd == idx) begin
            return memWb.wbData;
        end
        return regData;
    endfunction

    always_comb begin
        opA    = forward(idEx.rs1, idEx.rs1Data);
        rs2Fwd = forward(idEx.rs2, idEx.rs2Data);
        opB    = idEx.ctrl.srcBImm ? idEx.imm : rs2Fwd;
    end

    // loads, stores and lui all use the add
    always_comb begin
        case (idEx.ctrl.aluOp)
            AluAdd:  aluResult = opA + opB;
            AluSub:  aluResult = opA - opB;
            AluAnd:  aluResult = opA & opB;
            AluOr:   aluResult = opA | opB;
            AluXor:  aluResult = opA ^ opB;
            AluSlt:  aluResult = {31'b0, $signed(opA) < $signed(opB)};
            AluSll:  aluResult = opA << opB[4:0];
            AluSrl:  aluResult = opA >> opB[4:0];
            default: aluResult = opA + opB;
        endcase
    end

    // beq and bne only
    assign taken      = idEx.ctrl.isBranch && ((opA == rs2Fwd) != idEx.ctrl.branchNe);
    assign redirect   = idEx.valid && taken;
    assign redirectPc = idEx.pc + idEx.imm;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
        end else begin
            exMem <= '{valid: idEx.valid,
                       regWrEn: idEx.ctrl.regWrEn,
                       memRd: idEx.ctrl.memRd,
                       memWr: idEx.ctrl.memWr,
                       isHalt: idEx.ctrl.isHalt,
                       rd: idEx.rd,
                       aluResult: aluResult,
                       storeData: rs2Fwd};
        end
    end

    // a taken branch leaves a bubble behind it in ID/EX
    assert property (@(posedge CLK) disable iff (!arstN)
        redirect |=> !idEx.valid)
        else $error("redirect without squash of the younger instruction");

endmodule

// ==== hw/memWriteStage.sv ====
/* memory access: data request, writeback select, MEM/WB register and halt */
module memWriteStage
    import rvIsaPkg::*, pipePkg::*;
(
    input  logic    CLK,
    input  logic    arstN,
    input  exMemT   exMem,
    input  wordT    dataRdData,
    output dataReqT dataReq,
    output memWbT   memWb,
    output logic    halt
);

    logic haltLatched;

    // store happens on the next rising edge
    assign dataReq = '{addr: exMem.aluResult,
                       wrEn: exMem.valid && exMem.memWr,
                       wrData: exMem.storeData};

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            memWb       <= '0;
            haltLatched <= 1'b0;
        end else begin
            memWb <= '{valid: exMem.valid,
                       regWrEn: exMem.regWrEn,
                       isHalt: exMem.isHalt,
                       rd: exMem.rd,
                       wbData: exMem.memRd ? dataRdData : exMem.aluResult};
            if (memWb.valid && memWb.isHalt) begin
                haltLatched <= 1'b1;
            end
        end
    end

    // high from the halting writeback until reset
    assign halt = haltLatched || (memWb.valid && memWb.isHalt);

    // everything younger than the halting instruction was squashed
    assert property (@(posedge CLK) disable iff (!arstN)
        halt |-> !dataReq.wrEn)
        else $error("store issued after halt");

endmodule

// ==== hw/pipelineCpu.sv ====
/* five-stage RV32I subset core, top level connecting the four stages */
module pipelineCpu
    import rvIsaPkg::*, pipePkg::*;
#(
    parameter wordT ResetPc = '0
) (
    input  logic    CLK,
    input  logic    arstN,
    output wordT    instAddr,
    input  wordT    instWord,
    output dataReqT dataReq,
    input  wordT    dataRdData,
    output logic    halt
);

    ifIdT  ifId;
    idExT  idEx;
    exMemT exMem;
    memWbT memWb;
    logic  hold;
    logic  redirect;
    wordT  redirectPc;

    fetchStage #(
        .ResetPc    (ResetPc)
    ) i_fetchStage (
        .CLK        (CLK),
        .arstN      (arstN),
        .hold       (hold),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instWord   (instWord),
        .instAddr   (instAddr),
        .ifId       (ifId)
    );

    decodeStage i_decodeStage (
        .CLK        (CLK),
        .arstN      (arstN),
        .ifId       (ifId),
        .redirect   (redirect),
        .memWb      (memWb),
        .hold       (hold),
        .idEx       (idEx)
    );

    executeStage i_executeStage (
        .CLK        (CLK),
        .arstN      (arstN),
        .idEx       (idEx),
        .memWb      (memWb),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .exMem      (exMem)
    );

    memWriteStage i_memWriteStage (
        .CLK        (CLK),
        .arstN      (arstN),
        .exMem      (exMem),
        .dataRdData (dataRdData),
        .dataReq    (dataReq),
        .memWb      (memWb),
        .halt       (halt)
    );

endmodule

// ==== sim/cpuTbProgs.svh ====
/* instruction encoders for the kept RV32I subset and the program builders */
`ifndef CPU_TB_PROGS_SVH
`define CPU_TB_PROGS_SVH

function automatic wordT encR(logic [6:0] f7, regIdxT rs2, regIdxT rs1,
                              logic [2:0] f3, regIdxT rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic wordT encI(logic [6:0] op, logic [11:0] imm, regIdxT rs1,
                              logic [2:0] f3, regIdxT rd);
    return {imm, rs1, f3, rd, op};
endfunction

// sw only, base register and offset
function automatic wordT encS(logic [11:0] imm, regIdxT rs2, regIdxT rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

// beq when bne is low, offset in bytes
function automatic wordT encB(logic bne, logic [12:0] off, regIdxT rs2, regIdxT rs1);
    return {off[12], off[10:5], rs2, rs1, 2'b00, bne, off[4:1], off[11], 7'b1100011};
endfunction

function automatic wordT encU(logic [19:0] imm, regIdxT rd);
    return {imm, rd, 7'b0110111};
endfunction

task automatic newProgram();
    prog.delete();
    expStores.delete();
    haltIdx = -1;
endtask

task automatic emit(wordT w);
    prog.push_back(w);
endtask

// lui plus addi, upper part rounded up when the low twelve bits are negative
task automatic loadImm(regIdxT rd, wordT value);
    wordT upper;
    upper = value + 32'h0000_0800;
    emit(encU(upper[31:12], rd));
    emit(encI(7'b0010011, value[11:0], rd, 3'b000, rd));
endtask

// sw to an absolute address off x0, also recorded as expected
task automatic storeAt(regIdxT rs2, logic [11:0] addr, wordT value);
    dataReqT req;
    req = '{addr: {20'b0, addr}, wrEn: 1'b1, wrData: value};
    emit(encS(addr, rs2, 5'd0));
    expStores.push_back(req);
endtask

task automatic emitHalt(wordT w);
    haltIdx = prog.size();
    emit(w);
endtask

`endif

// ==== sim/cpuTb.sv ====
/* testbench for the pipelined core: clock, reset, memory models, store monitor,
   compare tasks, watchdog and the directed tests */
module cpuTb
    import rvIsaPkg::*, pipePkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int InstWords    = 128;
    localparam int DataWords    = 64;
    localparam int SettleCycles = 8;

    logic    CLK;
    logic    arstN;
    wordT    instAddr;
    wordT    instWord;
    dataReqT dataReq;
    wordT    dataRdData;
    logic    halt;

    wordT    instMem [InstWords];
    wordT    dataMem [DataWords];
    wordT    prog [$];
    dataReqT expStores [$];
    dataReqT stores [$];
    int      haltIdx;
    int      budget;
    int      cyclesUsed;
    int      errorCount;
    int      testsFailed;
    int      testsRun;
    int      seed;

    `include "cpuTbProgs.svh"

    pipelineCpu #(
        .ResetPc    (32'h0000_0000)
    ) i_pipelineCpu (
        .CLK        (CLK),
        .arstN      (arstN),
        .instAddr   (instAddr),
        .instWord   (instWord),
        .dataReq    (dataReq),
        .dataRdData (dataRdData),
        .halt       (halt)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // unused words decode as an illegal opcode, so a runaway fetch halts
    function automatic wordT instFill(int idx);
        return (wordT'(idx) << 7) | 32'h0000_007f;
    endfunction

    function automatic wordT dataFill(int idx);
        return 32'hc3a5_0000 ^ (wordT'(idx) * 32'h0101_0f07);
    endfunction

    // RV32I result by funct3, b is rs2 or the sign-extended immediate
    function automatic wordT isaResult(logic [2:0] f3, logic isSub, wordT a, wordT b);
        case (f3)
            3'b000:  return isSub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    assign instWord   = instMem[instAddr[8:2]];
    assign dataRdData = dataMem[dataReq.addr[7:2]];

    // data memory refills itself while reset is held
    always @(posedge CLK) begin
        if (!arstN) begin
            for (int i = 0; i < DataWords; i++) begin
                dataMem[i] <= dataFill(i);
            end
        end else if (dataReq.wrEn) begin
            dataMem[dataReq.addr[7:2]] <= dataReq.wrData;
        end
    end

    // each store is on the bus for one cycle
    always @(negedge CLK) begin
        if (dataReq.wrEn) begin
            stores.push_back(dataReq);
        end
    end

    task automatic checkStore(int idx, dataReqT got, dataReqT exp);
        if (got !== exp) begin
            $display("Error at %0d ns: dataReq store %0d expected %h/%h/%b, got %h/%h/%b",
                     $time, idx, exp.addr, exp.wrData, exp.wrEn,
                     got.addr, got.wrData, got.wrEn);
            errorCount++;
        end
    endtask

    task automatic checkWord(string name, wordT got, wordT exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, got);
            errorCount++;
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s expected %b, got %b", $time, name, exp, got);
            errorCount++;
        end
    endtask

    // load, reset, run to halt, then compare the store stream
    task automatic runProgram(string name);
        int   errorsBefore;
        int   storeBase;
        int   waited;
        wordT frozenPc;
        errorsBefore = errorCount;
        testsRun++;
        budget += prog.size() * 4 + 40;
        @(negedge CLK);
        arstN = 1'b0;
        foreach (instMem[i]) begin
            instMem[i] = (i < prog.size()) ? prog[i] : instFill(i);
        end
        repeat (3) @(negedge CLK);
        arstN     = 1'b1;
        storeBase = stores.size();
        waited    = 0;
        while (!halt && waited < prog.size() * 4 + 20) begin
            @(negedge CLK);
            waited++;
        end
        if (!halt) begin
            $display("test %s: core did not halt within %0d cycles", name, waited);
            errorCount++;
        end else begin
            // fetch stopped one word past the halting instruction's successor
            frozenPc = wordT'((haltIdx + 2) * 4);
            repeat (SettleCycles) begin
                @(negedge CLK);
                checkFlag("halt", halt, 1'b1);
                checkWord("instAddr", instAddr, frozenPc);
            end
        end
        if (stores.size() - storeBase != expStores.size()) begin
            $display("test %s: %0d stores seen where %0d were expected", name,
                     stores.size() - storeBase, expStores.size());
            errorCount++;
        end
        for (int k = 0; k < expStores.size() && storeBase + k < stores.size(); k++) begin
            checkStore(k, stores[storeBase + k], expStores[k]);
        end
        if (errorCount == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic testAluOps();
        logic [2:0]  f3List [7];
        logic [11:0] imm;
        logic [11:0] addr;
        wordT        a;
        wordT        b;
        f3List = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101, 3'b110, 3'b111};
        a      = 32'hf0f0_1357;
        b      = 32'h0000_0a63;
        addr   = 12'h080;
        newProgram();
        loadImm(5'd1, a);
        loadImm(5'd2, b);
        foreach (f3List[k]) begin
            emit(encR(7'b0000000, 5'd2, 5'd1, f3List[k], 5'd3));
            storeAt(5'd3, addr, isaResult(f3List[k], 1'b0, a, b));
            addr = addr + 12'h4;
        end
        emit(encR(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3));
        storeAt(5'd3, addr, isaResult(3'b000, 1'b1, a, b));
        addr = addr + 12'h4;
        // shifts take a five-bit shamt, the rest a negative immediate
        foreach (f3List[k]) begin
            imm = (f3List[k] inside {3'b001, 3'b101}) ? 12'h005 : 12'h9a5;
            emit(encI(7'b0010011, imm, 5'd1, f3List[k], 5'd4));
            storeAt(5'd4, addr, isaResult(f3List[k], 1'b0, a, {{20{imm[11]}}, imm}));
            addr = addr + 12'h4;
        end
        emit(encU(20'habcde, 5'd5));
        storeAt(5'd5, addr, 32'habcd_e000);
        emitHalt(32'h0000_0073);
        runProgram("aluOps");
    endtask

    task automatic testDependencies();
        wordT v1;
        wordT sum;
        wordT mix;
        wordT loaded;
        v1     = 32'h1234_5fed;
        sum    = v1 + v1;
        mix    = (sum - v1) ^ sum;
        loaded = dataFill(4);
        newProgram();
        loadImm(5'd1, v1);
        // every result is used by the very next instruction
        emit(encR(7'b0000000, 5'd1, 5'd1, 3'b000, 5'd2));
        emit(encR(7'b0100000, 5'd1, 5'd2, 3'b000, 5'd3));
        emit(encR(7'b0000000, 5'd2, 5'd3, 3'b100, 5'd4));
        storeAt(5'd4, 12'h020, mix);
        // load-use on rs1, then on the store data
        emit(encI(7'b0000011, 12'h010, 5'd0, 3'b010, 5'd5));
        emit(encI(7'b0010011, 12'h007, 5'd5, 3'b000, 5'd6));
        storeAt(5'd6, 12'h024, loaded + 32'd7);
        emit(encI(7'b0000011, 12'h020, 5'd0, 3'b010, 5'd7));
        storeAt(5'd7, 12'h028, mix);
        emit(encR(7'b0000000, 5'd6, 5'd5, 3'b000, 5'd8));
        storeAt(5'd8, 12'h02c, loaded + loaded + 32'd7);
        emitHalt(32'h0000_0073);
        runProgram("dependencies");
    endtask

    task automatic testBranches();
        newProgram();
        loadImm(5'd1, 32'd5);
        loadImm(5'd2, 32'd5);
        loadImm(5'd3, 32'd9);
        // beq taken over two stores
        emit(encB(1'b0, 13'd12, 5'd2, 5'd1));
        emit(encS(12'h090, 5'd3, 5'd0));
        emit(encS(12'h094, 5'd3, 5'd0));
        storeAt(5'd1, 12'h0a0, 32'd5);
        emit(encB(1'b1, 13'd8, 5'd2, 5'd1));
        storeAt(5'd2, 12'h0a4, 32'd5);
        storeAt(5'd3, 12'h0a8, 32'd9);
        // bne taken over one store
        emit(encB(1'b1, 13'd8, 5'd3, 5'd1));
        emit(encS(12'h0ac, 5'd3, 5'd0));
        storeAt(5'd3, 12'h0b0, 32'd9);
        emit(encB(1'b0, 13'd8, 5'd3, 5'd1));
        storeAt(5'd1, 12'h0b4, 32'd5);
        emitHalt(32'h0000_0073);
        runProgram("branches");
    endtask

    // older stores land, younger ones are squashed
    task automatic testHaltOn(string name, wordT haltWord);
        newProgram();
        loadImm(5'd1, 32'h0bad_f00d);
        storeAt(5'd1, 12'h040, 32'h0bad_f00d);
        storeAt(5'd0, 12'h044, 32'h0000_0000);
        emitHalt(haltWord);
        emit(encS(12'h048, 5'd1, 5'd0));
        emit(encS(12'h04c, 5'd1, 5'd0));
        emit(encS(12'h050, 5'd1, 5'd0));
        runProgram(name);
    endtask

    task automatic testRandomOps();
        logic [11:0] addr;
        wordT        x;
        wordT        y;
        wordT        s;
        wordT        d;
        addr = 12'h040;
        newProgram();
        repeat (5) begin
            x = $random(seed);
            y = $random(seed);
            s = x + y;
            d = s - x;
            loadImm(5'd1, x);
            loadImm(5'd2, y);
            emit(encR(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));
            emit(encR(7'b0100000, 5'd1, 5'd3, 3'b000, 5'd4));
            emit(encR(7'b0000000, 5'd3, 5'd4, 3'b100, 5'd5));
            storeAt(5'd3, addr, s);
            storeAt(5'd4, addr + 12'h4, d);
            storeAt(5'd5, addr + 12'h8, d ^ s);
            addr = addr + 12'hc;
        end
        emitHalt(32'h0000_0073);
        runProgram("randomOps");
    endtask

    initial begin
        arstN       = 1'b0;
        errorCount  = 0;
        testsFailed = 0;
        testsRun    = 0;
        budget      = 0;
        seed        = 32'h70f5;
        foreach (instMem[i]) begin
            instMem[i] = instFill(i);
        end
        testAluOps();
        testDependencies();
        testBranches();
        testHaltOn("ecallHalt", 32'h0000_0073);
        testHaltOn("unknownOpcodeHalt", 32'h0000_500b);
        testRandomOps();
        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (testsFailed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // budget grows by each program's length as the tests start
    initial begin
        cyclesUsed = 0;
        @(negedge CLK);
        while (cyclesUsed <= budget) begin
            @(negedge CLK);
            cyclesUsed++;
        end
        $display("watchdog expired after %0d cycles", cyclesUsed);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== pipelineCpu.f ====
+incdir+sim
hw/rvIsaPkg.sv
hw/pipePkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memWriteStage.sv
hw/pipelineCpu.sv
sim/cpuTb.sv

// ==== Makefile ====
# Verilator build and regression run for the pipelined core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		-f pipelineCpu.f --top-module cpuTb -Mdir obj_dir
	@out="$$(./obj_dir/VcpuTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
